/* design/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OP_R_TYPE   = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE   = 7'b0010011;
    localparam logic [6:0] OP_I_TYPE_L = 7'b0000011;  // Loads
    localparam logic [6:0] OP_S_TYPE   = 7'b0100011;
    localparam logic [6:0] OP_B_TYPE   = 7'b1100011;
    localparam logic [6:0] OP_J_TYPE   = 7'b1101111;  // JAL
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_ADD = 3'b000;  // Also SUB with funct7[5]
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_hi_lo;  // I-type immediate
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // ADDI x0,x0,0

endpackage

/* design/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    localparam logic [2:0] ALU_ADD    = 3'd0;
    localparam logic [2:0] ALU_SUB    = 3'd1;
    localparam logic [2:0] ALU_AND    = 3'd2;
    localparam logic [2:0] ALU_OR     = 3'd3;
    localparam logic [2:0] ALU_SLT    = 3'd4;
    localparam logic [2:0] ALU_PASS_B = 3'd5;

    // ALU operand sources
    localparam logic [1:0] SRC_REG  = 2'd0;
    localparam logic [1:0] SRC_IMM  = 2'd1;
    localparam logic [1:0] SRC_PC   = 2'd2;
    localparam logic [1:0] SRC_ZERO = 2'd3;

    // RES_ALU stays zero so a cleared control word is a bubble
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_J = 3'd3;
    localparam logic [2:0] IMM_U = 3'd4;

    localparam logic [1:0] PC_PLUS_4       = 2'd0;
    localparam logic [1:0] PC_PLUS_OFF     = 2'd1;
    localparam logic [1:0] PC_REG_PLUS_OFF = 2'd2;

    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_MEM  = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

    // rf_we, mem_we, alu_op, src_a, src_b, res_src, is_jump, is_jalr, is_branch
    localparam int CTRL_W = 14;

endpackage

/* design/hazard_if.sv */
interface hazard_if;
    logic [4:0] rs1_d, rs2_d;         // Decode sources
    logic [4:0] rs1_e, rs2_e, rd_e;
    logic [4:0] rd_m, rd_w;
    logic       rf_we_m, rf_we_w;
    logic       load_e;
    logic       redirect_e;           // Execute changes the PC
    logic [1:0] fwd_a, fwd_b;
    logic       stall, flush;

    modport dp (
        output rs1_d, rs2_d, rs1_e, rs2_e, rd_e, rd_m, rd_w,
        output rf_we_m, rf_we_w, load_e, redirect_e,
        input  fwd_a, fwd_b, stall, flush
    );

    modport hz (
        input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, rd_m, rd_w,
        input  rf_we_m, rf_we_w, load_e, redirect_e,
        output fwd_a, fwd_b, stall, flush
    );
endinterface

/* design/controller.sv */
module controller (
    input  riscv_isa_pkg::instr_u i_instr,
    output logic                  o_rf_we,
    output logic                  o_mem_we,
    output logic [2:0]            o_alu_op,
    output logic [1:0]            o_src_a,
    output logic [1:0]            o_src_b,
    output logic [1:0]            o_res_src,
    output logic [2:0]            o_imm_kind,
    output logic                  o_is_jump,
    output logic                  o_is_jalr,
    output logic                  o_is_branch
);
    logic [2:0] alu_f3;  // Shared by R-type and immediate arithmetic

    always_comb begin
        case (i_instr.r.funct3)
            riscv_isa_pkg::F3_SLT: alu_f3 = pipe_ctrl_pkg::ALU_SLT;
            riscv_isa_pkg::F3_OR:  alu_f3 = pipe_ctrl_pkg::ALU_OR;
            riscv_isa_pkg::F3_AND: alu_f3 = pipe_ctrl_pkg::ALU_AND;
            default:               alu_f3 = pipe_ctrl_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        // Unknown opcodes fall through as a NOP
        o_rf_we     = 1'b0;
        o_mem_we    = 1'b0;
        o_alu_op    = pipe_ctrl_pkg::ALU_ADD;
        o_src_a     = pipe_ctrl_pkg::SRC_REG;
        o_src_b     = pipe_ctrl_pkg::SRC_REG;
        o_res_src   = pipe_ctrl_pkg::RES_ALU;
        o_imm_kind  = pipe_ctrl_pkg::IMM_I;
        o_is_jump   = 1'b0;
        o_is_jalr   = 1'b0;
        o_is_branch = 1'b0;
        case (i_instr.r.opcode)
            riscv_isa_pkg::OP_R_TYPE: begin
                o_rf_we  = 1'b1;
                o_alu_op = (i_instr.r.funct3 == riscv_isa_pkg::F3_ADD && i_instr.r.funct7[5])
                           ? pipe_ctrl_pkg::ALU_SUB : alu_f3;
            end
            riscv_isa_pkg::OP_I_TYPE: begin
                o_rf_we  = 1'b1;
                o_alu_op = alu_f3;
                o_src_b  = pipe_ctrl_pkg::SRC_IMM;
            end
            riscv_isa_pkg::OP_I_TYPE_L: begin
                o_rf_we   = 1'b1;
                o_src_b   = pipe_ctrl_pkg::SRC_IMM;
                o_res_src = pipe_ctrl_pkg::RES_MEM;
            end
            riscv_isa_pkg::OP_S_TYPE: begin
                o_mem_we   = 1'b1;
                o_src_b    = pipe_ctrl_pkg::SRC_IMM;  // Address offset, store data comes from rs2
                o_imm_kind = pipe_ctrl_pkg::IMM_S;
            end
            riscv_isa_pkg::OP_B_TYPE: begin
                o_is_branch = 1'b1;
                o_alu_op    = pipe_ctrl_pkg::ALU_SUB;
                o_imm_kind  = pipe_ctrl_pkg::IMM_B;
            end
            riscv_isa_pkg::OP_J_TYPE: begin
                o_rf_we    = 1'b1;
                o_is_jump  = 1'b1;
                o_res_src  = pipe_ctrl_pkg::RES_PC4;
                o_imm_kind = pipe_ctrl_pkg::IMM_J;
            end
            riscv_isa_pkg::OP_JALR: begin
                o_rf_we   = 1'b1;
                o_is_jalr = 1'b1;
                o_res_src = pipe_ctrl_pkg::RES_PC4;
            end
            riscv_isa_pkg::OP_LUI: begin
                o_rf_we    = 1'b1;
                o_alu_op   = pipe_ctrl_pkg::ALU_PASS_B;
                o_src_a    = pipe_ctrl_pkg::SRC_ZERO;
                o_src_b    = pipe_ctrl_pkg::SRC_IMM;
                o_imm_kind = pipe_ctrl_pkg::IMM_U;
            end
            riscv_isa_pkg::OP_AUIPC: begin
                o_rf_we    = 1'b1;
                o_src_a    = pipe_ctrl_pkg::SRC_PC;
                o_src_b    = pipe_ctrl_pkg::SRC_IMM;
                o_imm_kind = pipe_ctrl_pkg::IMM_U;
            end
            default: ;
        endcase
    end
endmodule

/* design/regfile.sv */
module regfile (
    input  logic        clk,
    input  logic [4:0]  i_ra1,
    input  logic [4:0]  i_ra2,
    input  logic [4:0]  i_wa,
    input  logic [31:0] i_wd,
    input  logic        i_we,
    output logic [31:0] o_rd1,
    output logic [31:0] o_rd2
);
    logic [31:0] regs [0:31];

    // Falling edge write lets decode see write-back in the same cycle
    always_ff @(negedge clk) begin
        if (i_we && i_wa != 5'd0)
            regs[i_wa] <= i_wd;
    end

    assign o_rd1 = (i_ra1 == 5'd0) ? 32'd0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == 5'd0) ? 32'd0 : regs[i_ra2];
endmodule

/* design/alu.sv */
module alu (
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    input  logic [2:0]  i_op,
    output logic [31:0] o_y,
    output logic [3:0]  o_flags
);
    logic [32:0] diff;  // a + ~b + 1 with carry out in bit 32
    logic        neg;
    logic        zero;
    logic        carry;
    logic        ovf;

    assign diff  = {1'b0, i_a} + {1'b0, ~i_b} + 33'd1;
    assign neg   = diff[31];
    assign zero  = (diff[31:0] == 32'd0);
    assign carry = diff[32];               // Set when a >= b unsigned
    assign ovf   = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);

    assign o_flags = {neg, zero, carry, ovf};

    always_comb begin
        case (i_op)
            pipe_ctrl_pkg::ALU_ADD:    o_y = i_a + i_b;
            pipe_ctrl_pkg::ALU_SUB:    o_y = diff[31:0];
            pipe_ctrl_pkg::ALU_AND:    o_y = i_a & i_b;
            pipe_ctrl_pkg::ALU_OR:     o_y = i_a | i_b;
            pipe_ctrl_pkg::ALU_SLT:    o_y = {31'd0, neg ^ ovf};
            pipe_ctrl_pkg::ALU_PASS_B: o_y = i_b;
            default:                   o_y = 32'd0;
        endcase
    end
endmodule

/* design/hazard_ctrl.sv */
module hazard_ctrl (
    hazard_if.hz hz
);
    logic load_use;

    // Youngest producer wins and x0 is never forwarded
    function automatic logic [1:0] fwd_sel(input logic [4:0] rs);
        if (rs != 5'd0 && hz.rf_we_m && rs == hz.rd_m)
            return pipe_ctrl_pkg::FWD_MEM;
        if (rs != 5'd0 && hz.rf_we_w && rs == hz.rd_w)
            return pipe_ctrl_pkg::FWD_WB;
        return pipe_ctrl_pkg::FWD_NONE;
    endfunction

    always_comb begin
        hz.fwd_a = fwd_sel(hz.rs1_e);
        hz.fwd_b = fwd_sel(hz.rs2_e);
    end

    assign load_use = hz.load_e && hz.rd_e != 5'd0 &&
                      (hz.rd_e == hz.rs1_d || hz.rd_e == hz.rs2_d);

    assign hz.flush = hz.redirect_e;
    assign hz.stall = load_use && !hz.redirect_e;  // Decode is discarded on redirect
endmodule

/* design/datapath.sv */
module datapath (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_rf_we,
    input  logic                  i_mem_we,
    input  logic [2:0]            i_alu_op,
    input  logic [1:0]            i_src_a,
    input  logic [1:0]            i_src_b,
    input  logic [1:0]            i_res_src,
    input  logic [2:0]            i_imm_kind,
    input  logic                  i_is_jump,
    input  logic                  i_is_jalr,
    input  logic                  i_is_branch,
    hazard_if.dp                  hz,
    input  logic [31:0]           i_imem_data,
    input  logic [31:0]           i_dmem_rdata,
    output logic [31:0]           o_imem_addr,
    output logic [31:0]           o_dmem_addr,
    output logic [31:0]           o_dmem_wdata,
    output logic                  o_dmem_we,
    output logic                  o_wb_valid,
    output logic [4:0]            o_wb_rd,
    output logic [31:0]           o_wb_data,
    output riscv_isa_pkg::instr_u o_dec_instr
);
    logic [31:0]                      pc_f, pc_next, pc_d, pc_e, pc4_m;
    riscv_isa_pkg::instr_u            instr_d, instr_e;
    logic [31:0]                      rd1_d, rd2_d, imm_d, rd1_e, rd2_e, imm_e;
    logic [pipe_ctrl_pkg::CTRL_W-1:0] ctrl_d, ctrl_e;
    logic                             rf_we_e, mem_we_e, is_jump_e, is_jalr_e, is_branch_e;
    logic                             taken_e;
    logic [2:0]                       alu_op_e;
    logic [1:0]                       src_a_e, src_b_e, res_src_e, pc_src_e;
    logic [31:0]                      fwd_a_e, fwd_b_e, alu_a_e, alu_b_e, alu_y_e;
    logic [3:0]                       flags_e;  // neg, zero, carry, ovf
    logic                             rf_we_m, mem_we_m, rf_we_w;
    logic [1:0]                       res_src_m;
    logic [4:0]                       rd_m, rd_w;
    logic [31:0]                      alu_m, wdata_m, result_m, result_w;

    // Fetch
    assign o_imem_addr = pc_f;

    always_comb begin
        case (pc_src_e)
            pipe_ctrl_pkg::PC_PLUS_OFF:     pc_next = pc_e + imm_e;
            pipe_ctrl_pkg::PC_REG_PLUS_OFF: pc_next = (fwd_a_e + imm_e) & ~32'd1;
            default:                        pc_next = hz.stall ? pc_f : pc_f + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_f    <= 32'd0;
            instr_d <= riscv_isa_pkg::NOP_WORD;
            ctrl_e  <= '0;
        end else begin
            pc_f <= pc_next;
            if (hz.flush)
                instr_d <= riscv_isa_pkg::NOP_WORD;
            else if (!hz.stall)
                instr_d <= i_imem_data;
            ctrl_e <= (hz.stall || hz.flush) ? '0 : ctrl_d;  // Bubble into execute
        end
    end

    // Decode
    assign o_dec_instr = instr_d;
    assign ctrl_d = {i_rf_we, i_mem_we, i_alu_op, i_src_a, i_src_b, i_res_src,
                     i_is_jump, i_is_jalr, i_is_branch};

    regfile u_rf (
        .clk   (clk),
        .i_ra1 (instr_d.r.rs1),
        .i_ra2 (instr_d.r.rs2),
        .i_wa  (rd_w),
        .i_wd  (result_w),
        .i_we  (rf_we_w),
        .o_rd1 (rd1_d),
        .o_rd2 (rd2_d)
    );

    always_comb begin
        case (i_imm_kind)
            pipe_ctrl_pkg::IMM_S: imm_d = {{20{instr_d.r.funct7[6]}}, instr_d.r.funct7,
                                           instr_d.r.rd};
            pipe_ctrl_pkg::IMM_B: imm_d = {{20{instr_d.r.funct7[6]}}, instr_d.r.rd[0],
                                           instr_d.r.funct7[5:0], instr_d.r.rd[4:1], 1'b0};
            pipe_ctrl_pkg::IMM_J: imm_d = {{12{instr_d.r.funct7[6]}}, instr_d.r.rs1,
                                           instr_d.r.funct3, instr_d.r.rs2[0],
                                           instr_d.r.funct7[5:0], instr_d.r.rs2[4:1], 1'b0};
            pipe_ctrl_pkg::IMM_U: imm_d = {instr_d.r.funct7, instr_d.r.rs2, instr_d.r.rs1,
                                           instr_d.r.funct3, 12'd0};
            default:              imm_d = {{20{instr_d.i.imm_hi_lo[11]}}, instr_d.i.imm_hi_lo};
        endcase
    end

    // Payload stages
    always_ff @(posedge clk) begin
        if (!hz.stall)
            pc_d <= pc_f;
        pc_e     <= pc_d;
        instr_e  <= instr_d;
        rd1_e    <= rd1_d;
        rd2_e    <= rd2_d;
        imm_e    <= imm_d;
        alu_m    <= alu_y_e;
        wdata_m  <= fwd_b_e;
        pc4_m    <= pc_e + 32'd4;
        rd_m     <= instr_e.r.rd;
        result_w <= result_m;
        rd_w     <= rd_m;
    end

    // Execute
    assign {rf_we_e, mem_we_e, alu_op_e, src_a_e, src_b_e, res_src_e,
            is_jump_e, is_jalr_e, is_branch_e} = ctrl_e;

    function automatic logic [31:0] fwd_mux(input logic [1:0] sel, input logic [31:0] reg_val);
        case (sel)
            pipe_ctrl_pkg::FWD_MEM: return result_m;
            pipe_ctrl_pkg::FWD_WB:  return result_w;
            default:                return reg_val;
        endcase
    endfunction

    function automatic logic [31:0] operand(input logic [1:0] src, input logic [31:0] reg_val);
        case (src)
            pipe_ctrl_pkg::SRC_IMM:  return imm_e;
            pipe_ctrl_pkg::SRC_PC:   return pc_e;
            pipe_ctrl_pkg::SRC_ZERO: return 32'd0;
            default:                 return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a_e = fwd_mux(hz.fwd_a, rd1_e);
        fwd_b_e = fwd_mux(hz.fwd_b, rd2_e);
        alu_a_e = operand(src_a_e, fwd_a_e);
        alu_b_e = operand(src_b_e, fwd_b_e);
    end

    alu u_alu (
        .i_a     (alu_a_e),
        .i_b     (alu_b_e),
        .i_op    (alu_op_e),
        .o_y     (alu_y_e),
        .o_flags (flags_e)
    );

    always_comb begin
        case (instr_e.r.funct3)
            riscv_isa_pkg::F3_BEQ: taken_e = flags_e[2];
            riscv_isa_pkg::F3_BNE: taken_e = !flags_e[2];
            riscv_isa_pkg::F3_BLT: taken_e = flags_e[3] ^ flags_e[0];
            riscv_isa_pkg::F3_BGE: taken_e = !(flags_e[3] ^ flags_e[0]);
            default:               taken_e = 1'b0;
        endcase
        if (is_jalr_e)
            pc_src_e = pipe_ctrl_pkg::PC_REG_PLUS_OFF;
        else if (is_jump_e || (is_branch_e && taken_e))
            pc_src_e = pipe_ctrl_pkg::PC_PLUS_OFF;
        else
            pc_src_e = pipe_ctrl_pkg::PC_PLUS_4;
    end

    assign hz.rs1_d      = instr_d.r.rs1;
    assign hz.rs2_d      = instr_d.r.rs2;
    assign hz.rs1_e      = instr_e.r.rs1;
    assign hz.rs2_e      = instr_e.r.rs2;
    assign hz.rd_e       = instr_e.r.rd;
    assign hz.rd_m       = rd_m;
    assign hz.rd_w       = rd_w;
    assign hz.rf_we_m    = rf_we_m;
    assign hz.rf_we_w    = rf_we_w;
    assign hz.load_e     = (res_src_e == pipe_ctrl_pkg::RES_MEM);
    assign hz.redirect_e = (pc_src_e != pipe_ctrl_pkg::PC_PLUS_4);

    // Memory and write-back control
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rf_we_m   <= 1'b0;
            mem_we_m  <= 1'b0;
            res_src_m <= pipe_ctrl_pkg::RES_ALU;
            rf_we_w   <= 1'b0;
        end else begin
            rf_we_m   <= rf_we_e;
            mem_we_m  <= mem_we_e;
            res_src_m <= res_src_e;
            rf_we_w   <= rf_we_m;
        end
    end

    assign o_dmem_addr  = alu_m;
    assign o_dmem_wdata = wdata_m;
    assign o_dmem_we    = mem_we_m;

    always_comb begin
        case (res_src_m)
            pipe_ctrl_pkg::RES_MEM: result_m = i_dmem_rdata;
            pipe_ctrl_pkg::RES_PC4: result_m = pc4_m;
            default:                result_m = alu_m;
        endcase
    end

    assign o_wb_valid = rf_we_w && (rd_w != 5'd0);
    assign o_wb_rd    = rd_w;
    assign o_wb_data  = result_w;

    // Hazard unit must only forward from a stage that really writes
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (hz.fwd_a == pipe_ctrl_pkg::FWD_MEM || hz.fwd_b == pipe_ctrl_pkg::FWD_MEM) |-> rf_we_m)
        else $error("datapath: forward from memory stage without write enable");
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (hz.fwd_a == pipe_ctrl_pkg::FWD_WB || hz.fwd_b == pipe_ctrl_pkg::FWD_WB) |-> rf_we_w)
        else $error("datapath: forward from write-back stage without write enable");
endmodule

/* design/riscv_core.sv */
module riscv_core (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic [31:0] i_imem_data,
    input  logic [31:0] i_dmem_rdata,
    output logic [31:0] o_imem_addr,
    output logic [31:0] o_dmem_addr,
    output logic [31:0] o_dmem_wdata,
    output logic        o_dmem_we,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_rd,
    output logic [31:0] o_wb_data
);
    riscv_isa_pkg::instr_u dec_instr;
    logic                  rf_we, mem_we, is_jump, is_jalr, is_branch;
    logic [2:0]            alu_op, imm_kind;
    logic [1:0]            src_a, src_b, res_src;

    hazard_if hz_bus ();

    controller u_ctrl (
        .i_instr     (dec_instr),
        .o_rf_we     (rf_we),
        .o_mem_we    (mem_we),
        .o_alu_op    (alu_op),
        .o_src_a     (src_a),
        .o_src_b     (src_b),
        .o_res_src   (res_src),
        .o_imm_kind  (imm_kind),
        .o_is_jump   (is_jump),
        .o_is_jalr   (is_jalr),
        .o_is_branch (is_branch)
    );

    datapath u_dp (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_rf_we      (rf_we),
        .i_mem_we     (mem_we),
        .i_alu_op     (alu_op),
        .i_src_a      (src_a),
        .i_src_b      (src_b),
        .i_res_src    (res_src),
        .i_imm_kind   (imm_kind),
        .i_is_jump    (is_jump),
        .i_is_jalr    (is_jalr),
        .i_is_branch  (is_branch),
        .hz           (hz_bus.dp),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_dec_instr  (dec_instr)
    );

    hazard_ctrl u_hz (
        .hz (hz_bus.hz)
    );
endmodule

/* tests/riscv_core_tb.sv */
module riscv_core_tb;
    localparam int          TRACE_DEPTH = 128;
    localparam int          MEM_WORDS   = 64;
    localparam logic [39:0] SECTION_END = 40'hFF_FFFF_FFFF;
    localparam logic [31:0] FLUSH_MARK  = 32'h0000_07AD;  // Only skipped slots write this

    logic        clk = 1'b0;
    logic        i_arst_n;
    logic [31:0] i_imem_data;
    logic [31:0] i_dmem_rdata;
    logic [31:0] o_imem_addr;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic        o_dmem_we;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;

    logic [39:0] trace [0:TRACE_DEPTH-1];  // {behavior id, rd, data} or program word
    logic [31:0] imem  [0:MEM_WORDS-1];
    logic [31:0] dmem  [0:MEM_WORDS-1];
    logic        trace_ready = 1'b0;
    int          exp_base    = 0;
    int          exp_count   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    riscv_core uut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    always #20 clk = ~clk;

    // Both memories read combinationally, word addressed
    assign i_imem_data  = imem[o_imem_addr[7:2]];
    assign i_dmem_rdata = dmem[o_dmem_addr[7:2]];

    always @(posedge clk) begin
        if (o_dmem_we)
            dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;
    end

    function automatic string behavior_name(input logic [2:0] id);
        case (id)
            3'd1:    return "alu_ops";
            3'd2:    return "forwarding";
            3'd3:    return "load_store";
            3'd4:    return "branches";
            3'd5:    return "jumps";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        int n;
        int m;
        i_arst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            dmem[6'(i)] = 32'hD0D0_0000 | 32'(i * 4);  // Byte address in the low half
        $readmemh("tests/core_trace.mem", trace);
        n = 0;
        while (n < MEM_WORDS && trace[7'(n)] !== SECTION_END)
            n++;
        m = n + 1;  // Expected pairs start after the first marker
        while (m < TRACE_DEPTH && trace[7'(m)] !== SECTION_END)
            m++;
        if (n == 0 || n == MEM_WORDS || m == TRACE_DEPTH) begin
            $display("Trace file is missing a section marker or its program is empty");
            $display("Errors found");
            $fatal(1, "unusable trace file");
        end else begin
            for (int i = 0; i < n; i++)
                imem[6'(i)] = trace[7'(i)][31:0];
            exp_base    = n + 1;
            cycle_limit = 8 * n + 100;
            trace_ready = 1'b1;
            repeat (16) @(posedge clk);
            i_arst_n <= 1'b1;
        end
    end

    // Write-back monitor consumes one expected pair per valid cycle
    always @(posedge clk) begin
        logic [39:0] expected;
        if (trace_ready && i_arst_n && o_wb_valid) begin
            expected = trace[7'(exp_base + exp_count)];
            assert (o_wb_data !== FLUSH_MARK)
                else begin
                    $display("FAILED %s: expected no flushed write-back, actual x%0d = %h",
                             behavior_name(expected[39:37]), o_wb_rd, o_wb_data);
                    $display("Errors found");
                    $fatal(1, "flushed instruction wrote back");
                end
            assert (o_wb_rd === expected[36:32] && o_wb_data === expected[31:0])
                else begin
                    $display("FAILED %s: expected x%0d = %h, actual x%0d = %h",
                             behavior_name(expected[39:37]), expected[36:32], expected[31:0],
                             o_wb_rd, o_wb_data);
                    $display("Errors found");
                    $fatal(1, "write-back mismatch");
                end
            exp_count = exp_count + 1;
            if (trace[7'(exp_base + exp_count)] === SECTION_END) begin
                $display("No errors");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        if (trace_ready && i_arst_n) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > cycle_limit) begin
                $display("Timeout after %0d cycles before all expected write-backs were seen",
                         cycle_limit);
                $display("Errors found");
                $fatal(1, "timeout");
            end
        end
    end
endmodule

/* tests/core_trace.mem */
// Each entry is one 40-bit hex value: program words first, then a marker FFFFFFFFFF
// Expected write-back entries are {behavior id[2:0], rd[4:0], data[31:0]}, closed by the marker
00500093 FF900113 002081B3 40208233  // 0x00 addi x1 5, addi x2 -7, add x3, sub x4
0020F2B3 0020E333 001123B3 0020A433  // 0x10 and x5, or x6, slt x7, slt x8
0F017493 7000E513 123455B7 00001617  // 0x20 andi x9, ori x10, lui x11, auipc x12
00700693 00D686B3 00168013 00068733  // 0x30 addi x13, add x13 x13, addi x0, add x14
00D707B3 04000813 00F82023 00082883  // 0x40 add x15, addi x16, sw x15, lw x17
00188933 00308463 00100993 00318463  // 0x50 add x18 after load, beq not taken, addi x19, beq taken
7AD00A13 00319463 00200A93 00309463  // 0x60 skipped, bne not taken, addi x21, bne taken
7AD00B13 00114463 7AD00B93 0020C463  // 0x70 skipped, blt taken, skipped, blt not taken
00300C13 0020D463 7AD00C93 00115463  // 0x80 addi x24, bge taken, skipped, bge not taken
00400C93 00800D6F 7AD00E13 00CD0DE7  // 0x90 addi x25, jal x26, skipped, jalr x27
7AD00E13 001D8E93 0000006F 00000013  // 0xA0 skipped, addi x29, loop, nop
00000013                             // 0xB0 nop
FFFFFFFFFF
2100000005 22FFFFFFF9 23FFFFFFFE 240000000C  // ALU operations
2500000001 26FFFFFFFD 2700000001 2800000000
29000000F0 2A00000705 2B12345000 2C0000102C
4D00000007 4D0000000E 4E0000000E 4F0000001C  // Forwarding
7000000040 710000001C 7200000021             // Load and store
9300000001 9500000002 9800000003 9900000004  // Branches
BA00000098 BB000000A0 BD000000A1             // Jumps
FFFFFFFFFF

/* flist.f */
design/riscv_isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/hazard_if.sv
design/controller.sv
design/regfile.sv
design/alu.sv
design/hazard_ctrl.sv
design/datapath.sv
design/riscv_core.sv
tests/riscv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf $(OBJ_DIR)
